// File: build.f
+incdir+src
src/noc_bridge_pkg.sv
src/request_arbiter.sv
src/request_packetizer.sv
src/response_depacketizer.sv
src/noc_initiator_bridge.sv
verification/tb_noc_initiator_bridge.sv

// File: Makefile
TOP = tb_noc_initiator_bridge

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f build.f --top-module $(TOP) -o sim

run: build
	./obj_dir/sim | tee sim.log
	grep -q "Simulation passed" sim.log

lint:
	verilator --lint-only -Wall +incdir+src src/noc_bridge_pkg.sv src/request_arbiter.sv \
		src/request_packetizer.sv src/response_depacketizer.sv src/noc_initiator_bridge.sv \
		--top-module noc_initiator_bridge

clean:
	rm -rf obj_dir sim.log

// File: verification/tb_noc_initiator_bridge.sv
`include "noc_bridge_settings.svh"

module tb_noc_initiator_bridge;

    import noc_bridge_pkg::*;

    localparam int src_x = 1;
    localparam int src_y = 2;
    // The directed tests take about 150 cycles including stalls
    localparam int max_cycles = 5000;

    // Tid, tstrb, tlast and tdata of one request beat
    typedef logic [47:0] beat_t;

    logic                        ACLK;
    logic                        ARESETn;
    axi_id_t                     s_awid_i;
    addr_t                       s_awaddr_i;
    pkt_count_t                  s_awlen_i;
    logic [`NOC_SIZE_WIDTH-1:0]  s_awsize_i;
    logic [`NOC_BURST_WIDTH-1:0] s_awburst_i;
    logic                        s_awvalid_i;
    logic                        s_awready_o;
    data_t                       s_wdata_i;
    strb_t                       s_wstrb_i;
    logic                        s_wlast_i;
    logic                        s_wvalid_i;
    logic                        s_wready_o;
    axi_id_t                     s_arid_i;
    addr_t                       s_araddr_i;
    pkt_count_t                  s_arlen_i;
    logic [`NOC_SIZE_WIDTH-1:0]  s_arsize_i;
    logic [`NOC_BURST_WIDTH-1:0] s_arburst_i;
    logic                        s_arvalid_i;
    logic                        s_arready_o;
    logic                        s_bvalid_o;
    axi_id_t                     s_bid_o;
    logic                        s_bready_i;
    logic                        s_rvalid_o;
    axi_id_t                     s_rid_o;
    data_t                       s_rdata_o;
    logic                        s_rlast_o;
    logic                        s_rready_i;
    logic                        m_req_tvalid_o;
    stream_word_t                m_req_tdata_o;
    pkt_kind_t                   m_req_tid_o;
    strb_t                       m_req_tstrb_o;
    logic                        m_req_tlast_o;
    logic                        m_req_tready_i;
    logic                        s_resp_tvalid_i;
    stream_word_t                s_resp_tdata_i;
    pkt_kind_t                   s_resp_tid_i;
    logic                        s_resp_tlast_i;
    logic                        s_resp_tready_o;

    beat_t       seen_beats[$];
    beat_t       want_beats[$];
    data_t       wdata_list[4];
    strb_t       wstrb_list[4];
    logic [63:0] stall_bits;
    logic        stall_mode;
    int          aw_acks = 0;
    int          ar_acks = 0;
    int          b_beats = 0;
    int          r_beats = 0;
    int          cycle_count = 0;
    int          checks = 0;
    int          errors = 0;

    noc_initiator_bridge #(
        .router_x (src_x),
        .router_y (src_y)
    ) dut_i (.*);

    always begin
        ACLK = 1'b0;
        #5;
        ACLK = 1'b1;
        #5;
    end

    always @(posedge ACLK) begin
        cycle_count++;
        if (cycle_count >= max_cycles) begin
            $display("Timeout: the tests did not finish within %0d cycles", max_cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    // Request stream sink with random stalls when enabled
    initial begin
        logic [5:0] stall_idx;
        stall_idx = '0;
        m_req_tready_i = 1'b1;
        forever begin
            @(posedge ACLK);
            #1;
            m_req_tready_i = stall_mode ? stall_bits[stall_idx] : 1'b1;
            stall_idx = stall_idx + 6'd1;
        end
    end

    // Inputs only change just after the rising edge, so the falling edge sees the transfer
    always @(negedge ACLK) begin
        if (m_req_tvalid_o && m_req_tready_i) begin
            seen_beats.push_back({m_req_tid_o, m_req_tstrb_o, m_req_tlast_o, m_req_tdata_o});
        end
        if (s_awready_o) begin
            aw_acks++;
        end
        if (s_arready_o) begin
            ar_acks++;
        end
        if (s_bvalid_o && s_bready_i) begin
            b_beats++;
        end
        if (s_rvalid_o && s_rready_i) begin
            r_beats++;
        end
    end

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    function automatic beat_t header_beat(input int count, input int dst_x, input int dst_y);
        stream_word_t word;
        word = '0;
        word[1:0]  = 2'(dst_y);
        word[3:2]  = 2'(dst_x);
        word[5:4]  = 2'(src_y);
        word[7:6]  = 2'(src_x);
        word[15:8] = 8'(count);
        return {ROUTING_HEADER, 4'hf, 1'b0, word};
    endfunction

    // INCR bursts of 4-byte beats throughout
    function automatic beat_t ax_beat(input pkt_kind_t kind, input int id, input int addr,
                                      input int len, input logic last);
        stream_word_t word;
        word = '0;
        word[1:0]   = 2'd1;
        word[4:2]   = 3'd2;
        word[12:5]  = 8'(len);
        word[28:13] = 16'(addr);
        word[32:29] = 4'(id);
        return {kind, 4'hf, last, word};
    endfunction

    function automatic beat_t w_beat(input data_t data, input strb_t strb, input logic last);
        return {W_DATA, strb, last, 8'h00, data};
    endfunction

    task automatic expect_write(input int id, input int addr, input int len,
                                input int dst_x, input int dst_y);
        want_beats.push_back(header_beat(len + 2, dst_x, dst_y));
        want_beats.push_back(ax_beat(AW_SUBHEADER, id, addr, len, 1'b0));
        for (int i = 0; i <= len; i++) begin
            want_beats.push_back(w_beat(wdata_list[i], wstrb_list[i], i == len));
        end
    endtask

    task automatic expect_read(input int id, input int addr, input int len,
                               input int dst_x, input int dst_y);
        want_beats.push_back(header_beat(1, dst_x, dst_y));
        want_beats.push_back(ax_beat(AR_SUBHEADER, id, addr, len, 1'b1));
    endtask

    task automatic compare_beats(input string name, input int base);
        check_value({name, " beat count"}, 64'(want_beats.size()),
                    64'(seen_beats.size() - base));
        foreach (want_beats[i]) begin
            if (base + i < seen_beats.size()) begin
                check_value($sformatf("%s beat %0d", name, i), 64'(want_beats[i]),
                            64'(seen_beats[base + i]));
            end
        end
        want_beats.delete();
    endtask

    task automatic write_burst(input int id, input int addr, input int len);
        fork
            begin
                s_awid_i    = axi_id_t'(id);
                s_awaddr_i  = addr_t'(addr);
                s_awlen_i   = pkt_count_t'(len);
                s_awsize_i  = 3'd2;
                s_awburst_i = 2'd1;
                s_awvalid_i = 1'b1;
                do @(negedge ACLK); while (!s_awready_o);
                @(posedge ACLK);
                #1;
                s_awvalid_i = 1'b0;
            end
            begin
                for (int i = 0; i <= len; i++) begin
                    s_wdata_i  = wdata_list[i];
                    s_wstrb_i  = wstrb_list[i];
                    s_wlast_i  = (i == len);
                    s_wvalid_i = 1'b1;
                    do @(negedge ACLK); while (!s_wready_o);
                    @(posedge ACLK);
                    #1;
                end
                s_wvalid_i = 1'b0;
                s_wlast_i  = 1'b0;
            end
        join
    endtask

    task automatic read_request(input int id, input int addr, input int len);
        s_arid_i    = axi_id_t'(id);
        s_araddr_i  = addr_t'(addr);
        s_arlen_i   = pkt_count_t'(len);
        s_arsize_i  = 3'd2;
        s_arburst_i = 2'd1;
        s_arvalid_i = 1'b1;
        do @(negedge ACLK); while (!s_arready_o);
        @(posedge ACLK);
        #1;
        s_arvalid_i = 1'b0;
    endtask

    // Sends one response beat and checks the AXI side at the transfer
    task automatic send_response(input pkt_kind_t kind, input int id, input data_t data,
                                 input logic last);
        s_resp_tvalid_i = 1'b1;
        s_resp_tid_i    = kind;
        s_resp_tlast_i  = last;
        if (kind == R_DATA) begin
            s_resp_tdata_i = {4'h0, axi_id_t'(id), data};
        end
        else if (kind == B_SUBHEADER) begin
            s_resp_tdata_i = stream_word_t'(axi_id_t'(id));
        end
        else begin
            s_resp_tdata_i = 40'h00_0000_0146;
        end
        do @(negedge ACLK); while (!s_resp_tready_o);
        if (kind == B_SUBHEADER) begin
            check_value("response bvalid", 64'd1, 64'(s_bvalid_o));
            check_value("response bid", 64'(id), 64'(s_bid_o));
        end
        else if (kind == R_DATA) begin
            check_value("response rvalid", 64'd1, 64'(s_rvalid_o));
            check_value("response rid", 64'(id), 64'(s_rid_o));
            check_value("response rdata", 64'(data), 64'(s_rdata_o));
            check_value("response rlast", 64'(last), 64'(s_rlast_o));
        end
        else begin
            check_value("header bvalid", 64'd0, 64'(s_bvalid_o));
            check_value("header rvalid", 64'd0, 64'(s_rvalid_o));
        end
        @(posedge ACLK);
        #1;
        s_resp_tvalid_i = 1'b0;
    endtask

    task automatic reset_values();
        @(negedge ACLK);
        check_value("reset m_req_tvalid", 64'd0, 64'(m_req_tvalid_o));
        check_value("reset awready", 64'd0, 64'(s_awready_o));
        check_value("reset wready", 64'd0, 64'(s_wready_o));
        check_value("reset arready", 64'd0, 64'(s_arready_o));
        check_value("reset bvalid", 64'd0, 64'(s_bvalid_o));
        check_value("reset rvalid", 64'd0, 64'(s_rvalid_o));
        @(posedge ACLK);
        #1;
    endtask

    // ID 6 is node 5 at x 1 and y 1
    task automatic single_write(input string name);
        int base;
        int acks;
        base = seen_beats.size();
        acks = aw_acks;
        expect_write(6, 'h1a40, 3, 1, 1);
        write_burst(6, 'h1a40, 3);
        compare_beats(name, base);
        check_value({name, " awready count"}, 64'd1, 64'(aw_acks - acks));
    endtask

    // ID 3 is node 2 at x 2 and y 0
    task automatic single_read(input string name);
        int base;
        int acks;
        base = seen_beats.size();
        acks = ar_acks;
        expect_read(3, 'h0c80, 2, 2, 0);
        read_request(3, 'h0c80, 2);
        compare_beats(name, base);
        check_value({name, " arready count"}, 64'd1, 64'(ar_acks - acks));
    endtask

    task automatic simultaneous_requests();
        int base;
        base = seen_beats.size();
        expect_write(6, 'h2200, 1, 1, 1);
        expect_read(3, 'h0440, 0, 2, 0);
        fork
            write_burst(6, 'h2200, 1);
            read_request(3, 'h0440, 0);
        join
        compare_beats("simultaneous", base);
    endtask

    task automatic read_before_write();
        int base;
        base = seen_beats.size();
        expect_read(3, 'h0660, 1, 2, 0);
        expect_write(6, 'h3300, 1, 1, 1);
        fork
            read_request(3, 'h0660, 1);
            begin
                @(posedge ACLK);
                #1;
                write_burst(6, 'h3300, 1);
            end
        join
        compare_beats("read first", base);
    endtask

    task automatic response_packets();
        int   b_start;
        int   r_start;
        b_start = b_beats;
        r_start = r_beats;
        send_response(ROUTING_HEADER, 0, '0, 1'b0);
        send_response(B_SUBHEADER, 9, '0, 1'b1);
        check_value("b beat count", 64'd1, 64'(b_beats - b_start));
        send_response(ROUTING_HEADER, 0, '0, 1'b0);
        for (int i = 0; i < 3; i++) begin
            send_response(R_DATA, 5, $urandom, i == 2);
        end
        check_value("r beat count", 64'd3, 64'(r_beats - r_start));
        // RREADY low must hold the stream back
        send_response(ROUTING_HEADER, 0, '0, 1'b0);
        s_rready_i      = 1'b0;
        s_resp_tvalid_i = 1'b1;
        s_resp_tid_i    = R_DATA;
        s_resp_tdata_i  = {4'h0, 4'd5, 32'h5a5a_0f0f};
        s_resp_tlast_i  = 1'b1;
        repeat (2) begin
            @(negedge ACLK);
            check_value("stalled resp tready", 64'd0, 64'(s_resp_tready_o));
            check_value("stalled rvalid", 64'd1, 64'(s_rvalid_o));
        end
        @(posedge ACLK);
        #1;
        s_rready_i = 1'b1;
        send_response(R_DATA, 5, 32'h5a5a_0f0f, 1'b1);
        check_value("r beat count after stall", 64'd4, 64'(r_beats - r_start));
    endtask

    initial begin
        void'($urandom(32'h86aa_862c));
        ARESETn         = 1'b0;
        s_awid_i        = '0;
        s_awaddr_i      = '0;
        s_awlen_i       = '0;
        s_awsize_i      = '0;
        s_awburst_i     = '0;
        s_awvalid_i     = 1'b0;
        s_wdata_i       = '0;
        s_wstrb_i       = '0;
        s_wlast_i       = 1'b0;
        s_wvalid_i      = 1'b0;
        s_arid_i        = '0;
        s_araddr_i      = '0;
        s_arlen_i       = '0;
        s_arsize_i      = '0;
        s_arburst_i     = '0;
        s_arvalid_i     = 1'b0;
        s_bready_i      = 1'b1;
        s_rready_i      = 1'b1;
        s_resp_tvalid_i = 1'b0;
        s_resp_tdata_i  = '0;
        s_resp_tid_i    = ROUTING_HEADER;
        s_resp_tlast_i  = 1'b0;
        stall_mode      = 1'b0;
        stall_bits      = {$urandom, $urandom};
        for (int i = 0; i < 4; i++) begin
            wdata_list[i] = $urandom;
            wstrb_list[i] = strb_t'($urandom);
        end

        repeat (5) @(posedge ACLK);
        #1;
        ARESETn = 1'b1;

        reset_values();
        single_write("write");
        single_read("read");
        simultaneous_requests();
        read_before_write();
        stall_mode = 1'b1;
        single_write("stalled write");
        single_read("stalled read");
        stall_mode = 1'b0;
        response_packets();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end
        else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: src/noc_initiator_bridge.sv
`include "noc_bridge_settings.svh"

module noc_initiator_bridge #(
    parameter int router_x = 0,
    parameter int router_y = 0
) (
    input  logic                         ACLK,
    input  logic                         ARESETn,

    input  noc_bridge_pkg::axi_id_t      s_awid_i,
    input  noc_bridge_pkg::addr_t        s_awaddr_i,
    input  noc_bridge_pkg::pkt_count_t   s_awlen_i,
    input  logic [`NOC_SIZE_WIDTH-1:0]   s_awsize_i,
    input  logic [`NOC_BURST_WIDTH-1:0]  s_awburst_i,
    input  logic                         s_awvalid_i,
    output logic                         s_awready_o,

    input  noc_bridge_pkg::data_t        s_wdata_i,
    input  noc_bridge_pkg::strb_t        s_wstrb_i,
    input  logic                         s_wlast_i,
    input  logic                         s_wvalid_i,
    output logic                         s_wready_o,

    input  noc_bridge_pkg::axi_id_t      s_arid_i,
    input  noc_bridge_pkg::addr_t        s_araddr_i,
    input  noc_bridge_pkg::pkt_count_t   s_arlen_i,
    input  logic [`NOC_SIZE_WIDTH-1:0]   s_arsize_i,
    input  logic [`NOC_BURST_WIDTH-1:0]  s_arburst_i,
    input  logic                         s_arvalid_i,
    output logic                         s_arready_o,

    output logic                         s_bvalid_o,
    output noc_bridge_pkg::axi_id_t      s_bid_o,
    input  logic                         s_bready_i,

    output logic                         s_rvalid_o,
    output noc_bridge_pkg::axi_id_t      s_rid_o,
    output noc_bridge_pkg::data_t        s_rdata_o,
    output logic                         s_rlast_o,
    input  logic                         s_rready_i,

    output logic                         m_req_tvalid_o,
    output noc_bridge_pkg::stream_word_t m_req_tdata_o,
    output noc_bridge_pkg::pkt_kind_t    m_req_tid_o,
    output noc_bridge_pkg::strb_t        m_req_tstrb_o,
    output logic                         m_req_tlast_o,
    input  logic                         m_req_tready_i,

    input  logic                         s_resp_tvalid_i,
    input  noc_bridge_pkg::stream_word_t s_resp_tdata_i,
    input  noc_bridge_pkg::pkt_kind_t    s_resp_tid_i,
    input  logic                         s_resp_tlast_i,
    output logic                         s_resp_tready_o
);

    logic grant_valid;
    logic grant_write;
    logic pkt_done;

    request_arbiter u_request_arbiter (
        .ACLK          (ACLK),
        .ARESETn       (ARESETn),
        .aw_valid_i    (s_awvalid_i),
        .ar_valid_i    (s_arvalid_i),
        .pkt_done_i    (pkt_done),
        .grant_valid_o (grant_valid),
        .grant_write_o (grant_write)
    );

    request_packetizer #(
        .router_x (router_x),
        .router_y (router_y)
    ) u_request_packetizer (
        .ACLK           (ACLK),
        .ARESETn        (ARESETn),
        .grant_valid_i  (grant_valid),
        .grant_write_i  (grant_write),
        .s_awid_i       (s_awid_i),
        .s_awaddr_i     (s_awaddr_i),
        .s_awlen_i      (s_awlen_i),
        .s_awsize_i     (s_awsize_i),
        .s_awburst_i    (s_awburst_i),
        .s_awvalid_i    (s_awvalid_i),
        .s_awready_o    (s_awready_o),
        .s_wdata_i      (s_wdata_i),
        .s_wstrb_i      (s_wstrb_i),
        .s_wlast_i      (s_wlast_i),
        .s_wvalid_i     (s_wvalid_i),
        .s_wready_o     (s_wready_o),
        .s_arid_i       (s_arid_i),
        .s_araddr_i     (s_araddr_i),
        .s_arlen_i      (s_arlen_i),
        .s_arsize_i     (s_arsize_i),
        .s_arburst_i    (s_arburst_i),
        .s_arvalid_i    (s_arvalid_i),
        .s_arready_o    (s_arready_o),
        .m_req_tvalid_o (m_req_tvalid_o),
        .m_req_tdata_o  (m_req_tdata_o),
        .m_req_tid_o    (m_req_tid_o),
        .m_req_tstrb_o  (m_req_tstrb_o),
        .m_req_tlast_o  (m_req_tlast_o),
        .m_req_tready_i (m_req_tready_i),
        .pkt_done_o     (pkt_done)
    );

    response_depacketizer u_response_depacketizer (
        .s_resp_tvalid_i (s_resp_tvalid_i),
        .s_resp_tdata_i  (s_resp_tdata_i),
        .s_resp_tid_i    (s_resp_tid_i),
        .s_resp_tlast_i  (s_resp_tlast_i),
        .s_resp_tready_o (s_resp_tready_o),
        .s_bvalid_o      (s_bvalid_o),
        .s_bid_o         (s_bid_o),
        .s_bready_i      (s_bready_i),
        .s_rvalid_o      (s_rvalid_o),
        .s_rid_o         (s_rid_o),
        .s_rdata_o       (s_rdata_o),
        .s_rlast_o       (s_rlast_o),
        .s_rready_i      (s_rready_i)
    );

endmodule

// File: src/response_depacketizer.sv
`include "noc_bridge_settings.svh"

module response_depacketizer (
    input  logic                         s_resp_tvalid_i,
    input  noc_bridge_pkg::stream_word_t s_resp_tdata_i,
    input  noc_bridge_pkg::pkt_kind_t    s_resp_tid_i,
    input  logic                         s_resp_tlast_i,
    output logic                         s_resp_tready_o,

    output logic                         s_bvalid_o,
    output noc_bridge_pkg::axi_id_t      s_bid_o,
    input  logic                         s_bready_i,

    output logic                         s_rvalid_o,
    output noc_bridge_pkg::axi_id_t      s_rid_o,
    output noc_bridge_pkg::data_t        s_rdata_o,
    output logic                         s_rlast_o,
    input  logic                         s_rready_i
);

    import noc_bridge_pkg::*;

    // Payload fields are only qualified by the valids
    assign s_bid_o   = s_resp_tdata_i[`NOC_ID_WIDTH-1:0];
    assign s_rdata_o = s_resp_tdata_i[`NOC_DATA_WIDTH-1:0];
    assign s_rid_o   = s_resp_tdata_i[`NOC_DATA_WIDTH +: `NOC_ID_WIDTH];
    assign s_rlast_o = s_resp_tlast_i;

    always_comb begin
        s_bvalid_o = 1'b0;
        s_rvalid_o = 1'b0;

        case (s_resp_tid_i)
            B_SUBHEADER: begin
                s_bvalid_o      = s_resp_tvalid_i;
                s_resp_tready_o = s_bready_i;
            end
            R_DATA: begin
                s_rvalid_o      = s_resp_tvalid_i;
                s_resp_tready_o = s_rready_i;
            end
            // Routing headers and unknown codes are swallowed
            default: begin
                s_resp_tready_o = 1'b1;
            end
        endcase
    end

endmodule

// File: src/request_packetizer.sv
`include "noc_bridge_settings.svh"

module request_packetizer #(
    parameter int router_x = 0,
    parameter int router_y = 0
) (
    input  logic                             ACLK,
    input  logic                             ARESETn,

    input  logic                             grant_valid_i,
    input  logic                             grant_write_i,

    input  noc_bridge_pkg::axi_id_t          s_awid_i,
    input  noc_bridge_pkg::addr_t            s_awaddr_i,
    input  noc_bridge_pkg::pkt_count_t       s_awlen_i,
    input  logic [`NOC_SIZE_WIDTH-1:0]       s_awsize_i,
    input  logic [`NOC_BURST_WIDTH-1:0]      s_awburst_i,
    input  logic                             s_awvalid_i,
    output logic                             s_awready_o,

    input  noc_bridge_pkg::data_t            s_wdata_i,
    input  noc_bridge_pkg::strb_t            s_wstrb_i,
    input  logic                             s_wlast_i,
    input  logic                             s_wvalid_i,
    output logic                             s_wready_o,

    input  noc_bridge_pkg::axi_id_t          s_arid_i,
    input  noc_bridge_pkg::addr_t            s_araddr_i,
    input  noc_bridge_pkg::pkt_count_t       s_arlen_i,
    input  logic [`NOC_SIZE_WIDTH-1:0]       s_arsize_i,
    input  logic [`NOC_BURST_WIDTH-1:0]      s_arburst_i,
    input  logic                             s_arvalid_i,
    output logic                             s_arready_o,

    output logic                             m_req_tvalid_o,
    output noc_bridge_pkg::stream_word_t     m_req_tdata_o,
    output noc_bridge_pkg::pkt_kind_t        m_req_tid_o,
    output noc_bridge_pkg::strb_t            m_req_tstrb_o,
    output logic                             m_req_tlast_o,
    input  logic                             m_req_tready_i,

    output logic                             pkt_done_o
);

    import noc_bridge_pkg::*;

    req_state_t   state;
    req_state_t   state_next;
    axi_id_t      hdr_id;
    axi_id_t      hdr_node;
    pkt_count_t   hdr_count;
    coord_t       dst_x;
    coord_t       dst_y;
    stream_word_t header_word;
    stream_word_t aw_word;
    stream_word_t ar_word;
    stream_word_t w_word;

    // AW and AR subheaders share one layout
    function automatic stream_word_t pack_ax(
        input axi_id_t                    id,
        input addr_t                      addr,
        input pkt_count_t                 len,
        input logic [`NOC_SIZE_WIDTH-1:0]  size,
        input logic [`NOC_BURST_WIDTH-1:0] burst
    );
        pack_ax = {{`NOC_AX_RSVD_WIDTH{1'b0}}, id, addr, len, size, burst};
    endfunction

    // ID n addresses mesh node n-1, numbered row by row
    always_comb begin
        if (grant_write_i) begin
            hdr_id    = s_awid_i;
            hdr_count = s_awlen_i + pkt_count_t'(2);
        end
        else begin
            hdr_id    = s_arid_i;
            hdr_count = pkt_count_t'(1);
        end
        hdr_node = hdr_id - axi_id_t'(1);
        dst_x    = coord_t'(hdr_node % `NOC_ROUTERS_X);
        dst_y    = coord_t'((hdr_node / `NOC_ROUTERS_X) % `NOC_ROUTERS_Y);
    end

    assign header_word = {{`NOC_HDR_RSVD_WIDTH{1'b0}}, hdr_count,
                          coord_t'(router_x), coord_t'(router_y), dst_x, dst_y};
    assign aw_word = pack_ax(s_awid_i, s_awaddr_i, s_awlen_i, s_awsize_i, s_awburst_i);
    assign ar_word = pack_ax(s_arid_i, s_araddr_i, s_arlen_i, s_arsize_i, s_arburst_i);
    assign w_word  = {{`NOC_W_RSVD_WIDTH{1'b0}}, s_wdata_i};

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            state <= GENERATE_HEADER;
        end
        else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next     = state;
        m_req_tvalid_o = 1'b0;
        m_req_tdata_o  = '0;
        m_req_tid_o    = ROUTING_HEADER;
        m_req_tstrb_o  = '1;
        m_req_tlast_o  = 1'b0;
        s_awready_o    = 1'b0;
        s_wready_o     = 1'b0;
        s_arready_o    = 1'b0;
        pkt_done_o     = 1'b0;

        case (state)
            GENERATE_HEADER: begin
                m_req_tvalid_o = grant_valid_i;
                m_req_tdata_o  = header_word;
                if (grant_valid_i && m_req_tready_i) begin
                    state_next = grant_write_i ? AW_SEND : AR_SEND;
                end
            end
            AW_SEND: begin
                m_req_tvalid_o = s_awvalid_i;
                m_req_tdata_o  = aw_word;
                m_req_tid_o    = AW_SUBHEADER;
                if (s_awvalid_i && m_req_tready_i) begin
                    state_next = W_SEND;
                end
            end
            W_SEND: begin
                // AW is held until the burst has gone out
                m_req_tvalid_o = s_wvalid_i;
                m_req_tdata_o  = w_word;
                m_req_tid_o    = W_DATA;
                m_req_tstrb_o  = s_wstrb_i;
                m_req_tlast_o  = s_wlast_i;
                s_wready_o     = m_req_tready_i;
                s_awready_o    = m_req_tready_i & s_wvalid_i & s_wlast_i;
                pkt_done_o     = m_req_tready_i & s_wvalid_i & s_wlast_i;
                if (m_req_tready_i && s_wvalid_i && s_wlast_i) begin
                    state_next = GENERATE_HEADER;
                end
            end
            AR_SEND: begin
                m_req_tvalid_o = s_arvalid_i;
                m_req_tdata_o  = ar_word;
                m_req_tid_o    = AR_SUBHEADER;
                m_req_tlast_o  = 1'b1;
                s_arready_o    = m_req_tready_i;
                pkt_done_o     = m_req_tready_i & s_arvalid_i;
                if (m_req_tready_i && s_arvalid_i) begin
                    state_next = GENERATE_HEADER;
                end
            end
            default: begin
                state_next = GENERATE_HEADER;
            end
        endcase
    end

endmodule

// File: src/request_arbiter.sv
module request_arbiter (
    input  logic ACLK,
    input  logic ARESETn,
    input  logic aw_valid_i,
    input  logic ar_valid_i,
    input  logic pkt_done_i,
    output logic grant_valid_o,
    output logic grant_write_o
);

    logic prefer_write;
    logic locked;
    logic locked_write;

    // Free choice only while no packet is in flight
    always_comb begin
        if (locked) begin
            grant_valid_o = 1'b1;
            grant_write_o = locked_write;
        end
        else begin
            grant_valid_o = aw_valid_i | ar_valid_i;
            grant_write_o = aw_valid_i & (prefer_write | ~ar_valid_i);
        end
    end

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            prefer_write <= 1'b1;
            locked       <= 1'b0;
            locked_write <= 1'b0;
        end
        else if (!locked) begin
            // Freeze the choice made in the first header cycle
            if (aw_valid_i || ar_valid_i) begin
                locked       <= 1'b1;
                locked_write <= grant_write_o;
            end
        end
        else if (pkt_done_i) begin
            locked       <= 1'b0;
            prefer_write <= ~locked_write;
        end
    end

endmodule

// File: src/noc_bridge_pkg.sv
`include "noc_bridge_settings.svh"

package noc_bridge_pkg;

    typedef logic [`NOC_ADDR_WIDTH-1:0] addr_t;
    typedef logic [`NOC_DATA_WIDTH-1:0] data_t;
    typedef logic [`NOC_ID_WIDTH-1:0] axi_id_t;
    typedef logic [`NOC_COORD_WIDTH-1:0] coord_t;
    typedef logic [`NOC_COUNT_WIDTH-1:0] pkt_count_t;
    typedef logic [`NOC_CHANNEL_WIDTH-1:0] stream_word_t;
    typedef logic [`NOC_STRB_WIDTH-1:0] strb_t;

    typedef enum logic [`NOC_TID_WIDTH-1:0] {
        ROUTING_HEADER = `NOC_TID_ROUTING_HEADER,
        AW_SUBHEADER   = `NOC_TID_AW_SUBHEADER,
        W_DATA         = `NOC_TID_W_DATA,
        AR_SUBHEADER   = `NOC_TID_AR_SUBHEADER,
        B_SUBHEADER    = `NOC_TID_B_SUBHEADER,
        R_DATA         = `NOC_TID_R_DATA
    } pkt_kind_t;

    // Request packetizer states
    typedef enum logic [1:0] {
        GENERATE_HEADER,
        AW_SEND,
        W_SEND,
        AR_SEND
    } req_state_t;

endpackage

// File: src/noc_bridge_settings.svh
`ifndef NOC_BRIDGE_SETTINGS_SVH
`define NOC_BRIDGE_SETTINGS_SVH

// AXI side
`define NOC_ADDR_WIDTH 16
`define NOC_DATA_WIDTH 32
`define NOC_ID_WIDTH 4
`define NOC_STRB_WIDTH 4
`define NOC_SIZE_WIDTH 3
`define NOC_BURST_WIDTH 2

// Stream side
`define NOC_CHANNEL_WIDTH 40
`define NOC_TID_WIDTH 3

// Mesh
`define NOC_ROUTERS_X 4
`define NOC_ROUTERS_Y 4
`define NOC_COORD_WIDTH 2
`define NOC_COUNT_WIDTH 8

// Packet codes carried on TID
`define NOC_TID_ROUTING_HEADER 3'd0
`define NOC_TID_AW_SUBHEADER 3'd1
`define NOC_TID_W_DATA 3'd2
`define NOC_TID_AR_SUBHEADER 3'd3
`define NOC_TID_B_SUBHEADER 3'd4
`define NOC_TID_R_DATA 3'd5

// Zero padding above the used fields of each request word
`define NOC_HDR_RSVD_WIDTH (`NOC_CHANNEL_WIDTH - `NOC_COUNT_WIDTH - 4 * `NOC_COORD_WIDTH)
`define NOC_AX_RSVD_WIDTH (`NOC_CHANNEL_WIDTH - `NOC_ID_WIDTH - `NOC_ADDR_WIDTH - \
    `NOC_COUNT_WIDTH - `NOC_SIZE_WIDTH - `NOC_BURST_WIDTH)
`define NOC_W_RSVD_WIDTH (`NOC_CHANNEL_WIDTH - `NOC_DATA_WIDTH)

`endif
